// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --top-module rv_exec_tb -f rv_exec_top.f -o rv_exec_sim
out="$(./obj_dir/rv_exec_sim)"
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
   exit 0
fi
exit 1

// File: rv_exec_top.f
+incdir+src
src/riscv_isa_pkg.sv
src/core_pkg.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/apb_exec_port.sv
src/rv_exec_top.sv
verification/rv_exec_tb.sv

// File: src/alu.sv
`default_nettype none

`include "core_macros.svh"

module alu
   import core_pkg::*;
(
   input  alu_op_e            op_i,
   input  logic [`XLEN_W-1:0] a_i,
   input  logic [`XLEN_W-1:0] b_i,
   output logic [`XLEN_W-1:0] result_o
);

   logic [4:0] shamt;
   logic       lt_signed;
   logic       lt_unsigned;

   assign shamt       = b_i[4:0]; // RV32I uses the low five bits.
   assign lt_signed   = $signed(a_i) < $signed(b_i);
   assign lt_unsigned = a_i < b_i;

   always_comb begin
      case (op_i)
         ADD:     result_o = a_i + b_i;
         SUB:     result_o = a_i - b_i;
         SLL:     result_o = a_i << shamt;
         SLT:     result_o = {{(`XLEN_W-1){1'b0}}, lt_signed};
         SLTU:    result_o = {{(`XLEN_W-1){1'b0}}, lt_unsigned};
         XOR:     result_o = a_i ^ b_i;
         SRL:     result_o = a_i >> shamt;
         SRA:     result_o = $unsigned($signed(a_i) >>> shamt);
         OR:      result_o = a_i | b_i;
         AND:     result_o = a_i & b_i;
         PASS_B:  result_o = b_i;
         default: result_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: src/apb_exec_port.sv
`default_nettype none

`include "core_macros.svh"

module apb_exec_port
   import core_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_i,
   input  apb_req_t               apb_req_i,
   output logic [`XLEN_W-1:0]     prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output logic [`XLEN_W-1:0]     instr_o,
   output logic                   issue_o,
   input  logic                   illegal_i,
   output logic [`REG_ADDR_W-1:0] host_raddr_o,
   input  logic [`XLEN_W-1:0]     host_rdata_i
);

   localparam logic [`APB_ADDR_W-1:0] reg_top =
      `APB_ADDR_W'(`ADDR_REG_BASE + 4 * `NUM_REGS);

   logic               access;
   logic               wr_en;
   logic               sel_instr;
   logic               sel_status;
   logic               sel_reg;
   logic [`XLEN_W-1:0] instr_q;
   logic               issue_q;
   status_t            status_q;

   assign access     = apb_req_i.psel && apb_req_i.penable;
   assign wr_en      = access && apb_req_i.pwrite; // Commits at the end of the access cycle.
   assign sel_instr  = (apb_req_i.paddr == `ADDR_INSTR);
   assign sel_status = (apb_req_i.paddr == `ADDR_STATUS);
   assign sel_reg    = (apb_req_i.paddr >= `ADDR_REG_BASE) && (apb_req_i.paddr < reg_top) &&
                       (apb_req_i.paddr[1:0] == 2'b00);

   assign host_raddr_o = apb_req_i.paddr[`REG_ADDR_W+1:2];

   always_ff @(posedge clk) begin
      if (wr_en && sel_instr) begin
         instr_q <= apb_req_i.pwdata;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         issue_q  <= 1'b0;
         status_q <= '0;
      end else begin
         issue_q <= wr_en && sel_instr;
         if (wr_en && sel_status) begin
            status_q <= '0;
         end else if (issue_q) begin // Decode result is valid one cycle after the write.
            if (illegal_i) begin
               status_q.illegal_seen <= 1'b1;
            end else begin
               status_q.retired_count <= status_q.retired_count + 1'b1;
            end
         end
      end
   end

   always_comb begin
      prdata_o = '0;
      if (apb_req_i.psel && !apb_req_i.pwrite) begin
         if (sel_status) begin
            prdata_o = status_q;
         end else if (sel_reg) begin
            prdata_o = host_rdata_i;
         end
      end
   end

   // Register window is read only.
   assign pslverr_o = access && ((sel_reg && apb_req_i.pwrite) ||
                                 !(sel_instr || sel_status || sel_reg));
   assign pready_o  = 1'b1;
   assign instr_o   = instr_q;
   assign issue_o   = issue_q;

endmodule

`default_nettype wire

// File: src/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath sizes.
`define XLEN_W      32
`define NUM_REGS    32
`define REG_ADDR_W  5

// APB address map.
`define APB_ADDR_W     12
`define ADDR_INSTR     12'h000 // Write only.
`define ADDR_STATUS    12'h004 // Read, any write clears.
`define ADDR_REG_BASE  12'h080 // Register xn at base + 4*n.

`endif

// File: src/core_pkg.sv
`default_nettype none

`include "core_macros.svh"

package core_pkg;

   typedef enum logic [3:0] {
      ADD,
      SUB,
      SLL,
      SLT,
      SLTU,
      XOR,
      SRL,
      SRA,
      OR,
      AND,
      PASS_B // LUI.
   } alu_op_e;

   typedef struct packed {
      logic [`REG_ADDR_W-1:0] rs1;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rd;
      alu_op_e                alu_op;
      logic                   use_imm;
      logic [`XLEN_W-1:0]     imm;
      logic                   we;
      logic                   illegal;
   } decoded_t;

   typedef struct packed {
      logic                   we;
      logic [`REG_ADDR_W-1:0] addr;
      logic [`XLEN_W-1:0]     data;
   } wb_t;

   typedef struct packed {
      logic                   psel;
      logic                   penable;
      logic                   pwrite;
      logic [`APB_ADDR_W-1:0] paddr;
      logic [`XLEN_W-1:0]     pwdata;
   } apb_req_t;

   typedef struct packed {
      logic        illegal_seen;  // Sticky.
      logic [14:0] reserved;
      logic [15:0] retired_count; // Wraps.
   } status_t;

endpackage

`default_nettype wire

// File: src/decoder.sv
`default_nettype none

`include "core_macros.svh"

module decoder
   import riscv_isa_pkg::*;
   import core_pkg::*;
(
   input  instruction_t instr_i,
   output decoded_t     dec_o
);

   // Operation for funct3 with funct7 at its base value.
   function automatic alu_op_e base_op(input funct3_e f3);
      alu_op_e op;
      case (f3)
         ADD_F3:  op = ADD;
         SLL_F3:  op = SLL;
         SLT_F3:  op = SLT;
         SLTU_F3: op = SLTU;
         XOR_F3:  op = XOR;
         SR_F3:   op = SRL;
         OR_F3:   op = OR;
         AND_F3:  op = AND;
         default: op = ADD;
      endcase
      return op;
   endfunction

   always_comb begin
      dec_o        = '0;
      dec_o.rs1    = instr_i.rtype.rs1;
      dec_o.rs2    = instr_i.rtype.rs2;
      dec_o.rd     = instr_i.rtype.rd;
      dec_o.alu_op = base_op(instr_i.rtype.funct3);
      dec_o.imm    = {{(`XLEN_W-12){instr_i.itype.imm[11]}}, instr_i.itype.imm};

      case (instr_i.itype.opcode)
         I_OP: begin
            dec_o.use_imm = 1'b1;
            dec_o.we      = 1'b1;
            // Only shifts carry funct7 in the immediate.
            if (instr_i.itype.funct3 == SR_F3 && instr_i.rtype.funct7 == ALT) begin
               dec_o.alu_op = SRA;
            end else if (instr_i.itype.funct3 == SLL_F3 || instr_i.itype.funct3 == SR_F3) begin
               dec_o.illegal = (instr_i.rtype.funct7 != BASE);
            end
         end

         RR_OP: begin
            dec_o.we = 1'b1;
            if (instr_i.rtype.funct7 == ALT) begin
               case (instr_i.rtype.funct3)
                  ADD_F3:  dec_o.alu_op = SUB;
                  SR_F3:   dec_o.alu_op = SRA;
                  default: dec_o.illegal = 1'b1;
               endcase
            end else if (instr_i.rtype.funct7 != BASE) begin
               dec_o.illegal = 1'b1;
            end
         end

         LUI_OP: begin
            dec_o.use_imm = 1'b1;
            dec_o.we      = 1'b1;
            dec_o.alu_op  = PASS_B;
            dec_o.imm     = {instr_i.utype.imm, 12'b0};
         end

         // No memory, PC or system state behind these.
         AUI_OP, L_OP, S_OP, B_OP, JAL_OP, JALR_OP, E_OP: begin
            dec_o.illegal = 1'b1;
         end

         default: dec_o.illegal = 1'b1;
      endcase

      if (dec_o.illegal) begin
         dec_o.we = 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`default_nettype none

`include "core_macros.svh"

module reg_file
   import core_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_i,
   input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
   input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
   input  logic [`REG_ADDR_W-1:0] host_raddr_i,
   input  wb_t                    wb_i,
   output logic [`XLEN_W-1:0]     rs1_data_o,
   output logic [`XLEN_W-1:0]     rs2_data_o,
   output logic [`XLEN_W-1:0]     host_rdata_o
);

   logic [`XLEN_W-1:0] regs [`NUM_REGS];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_i.we && wb_i.addr != '0) begin
         regs[wb_i.addr] <= wb_i.data;
      end
   end

   // x0 reads zero regardless of the array contents.
   assign rs1_data_o   = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
   assign rs2_data_o   = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
   assign host_rdata_o = (host_raddr_i == '0) ? '0 : regs[host_raddr_i];

endmodule

`default_nettype wire

// File: src/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

   typedef enum logic [6:0] {
      I_OP    = 7'b0010011,
      RR_OP   = 7'b0110011,
      LUI_OP  = 7'b0110111,
      AUI_OP  = 7'b0010111,
      L_OP    = 7'b0000011,
      S_OP    = 7'b0100011,
      B_OP    = 7'b1100011,
      JAL_OP  = 7'b1101111,
      JALR_OP = 7'b1100111,
      E_OP    = 7'b1110011
   } opcode_e;

   // Shared by OP-IMM and OP.
   typedef enum logic [2:0] {
      ADD_F3  = 3'b000,
      SLL_F3  = 3'b001,
      SLT_F3  = 3'b010,
      SLTU_F3 = 3'b011,
      XOR_F3  = 3'b100,
      SR_F3   = 3'b101,
      OR_F3   = 3'b110,
      AND_F3  = 3'b111
   } funct3_e;

   typedef enum logic [6:0] {
      BASE = 7'b0000000,
      ALT  = 7'b0100000 // SUB, SRA, SRAI.
   } funct7_e;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      funct3_e     funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
   } itype_t;

   typedef struct packed {
      funct7_e    funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      funct3_e    funct3;
      logic [4:0] rd;
      opcode_e    opcode;
   } rtype_t;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      opcode_e     opcode;
   } utype_t;

   typedef union packed {
      logic [31:0] raw;
      itype_t      itype;
      rtype_t      rtype;
      utype_t      utype;
   } instruction_t;

   // ABI names, in register number order.
   typedef enum logic [4:0] {
      zero, ra, sp, gp, tp,
      t0, t1, t2,
      s0, s1,
      a0, a1, a2, a3, a4, a5, a6, a7,
      s2, s3, s4, s5, s6, s7, s8, s9, s10, s11,
      t3, t4, t5, t6
   } reg_name_e;

endpackage

`default_nettype wire

// File: src/rv_exec_top.sv
`default_nettype none

`include "core_macros.svh"

module rv_exec_top
   import core_pkg::*;
(
   input  logic               clk,
   input  logic               reset_i,
   input  apb_req_t           apb_req_i,
   output logic [`XLEN_W-1:0] prdata_o,
   output logic               pready_o,
   output logic               pslverr_o
);

   logic [`XLEN_W-1:0]     instr;
   logic                   issue;
   decoded_t               dec;
   logic [`REG_ADDR_W-1:0] host_raddr;
   logic [`XLEN_W-1:0]     host_rdata;
   logic [`XLEN_W-1:0]     rs1_data;
   logic [`XLEN_W-1:0]     rs2_data;
   logic [`XLEN_W-1:0]     alu_b;
   logic [`XLEN_W-1:0]     alu_result;
   wb_t                    wb;

   apb_exec_port apb_exec_port_i (
      .clk          (clk),
      .reset_i      (reset_i),
      .apb_req_i    (apb_req_i),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .instr_o      (instr),
      .issue_o      (issue),
      .illegal_i    (dec.illegal),
      .host_raddr_o (host_raddr),
      .host_rdata_i (host_rdata)
   );

   decoder decoder_i (
      .instr_i (instr),
      .dec_o   (dec)
   );

   reg_file reg_file_i (
      .clk          (clk),
      .reset_i      (reset_i),
      .rs1_addr_i   (dec.rs1),
      .rs2_addr_i   (dec.rs2),
      .host_raddr_i (host_raddr),
      .wb_i         (wb),
      .rs1_data_o   (rs1_data),
      .rs2_data_o   (rs2_data),
      .host_rdata_o (host_rdata)
   );

   assign alu_b = dec.use_imm ? dec.imm : rs2_data;

   alu alu_i (
      .op_i     (dec.alu_op),
      .a_i      (rs1_data),
      .b_i      (alu_b),
      .result_o (alu_result)
   );

   assign wb.we   = issue && dec.we && !dec.illegal; // Written in the cycle after issue.
   assign wb.addr = dec.rd;
   assign wb.data = alu_result;

endmodule

`default_nettype wire

// File: verification/rv_exec_tb.sv
`default_nettype none

`include "core_macros.svh"

module rv_exec_tb
   import riscv_isa_pkg::*;
   import core_pkg::*;
();

   localparam int TIMEOUT = 16;

   logic               clk = 1'b0;
   logic               reset_i;
   apb_req_t           apb_req;
   logic [`XLEN_W-1:0] prdata;
   logic               pready;
   logic               pslverr;
   logic [`XLEN_W-1:0] shadow [`NUM_REGS]; // Expected register contents.
   logic               exp_illegal;
   logic [15:0]        exp_retired;
   int                 checks;
   int                 errors;
   int                 test_errors;
   string              cur_test;

   rv_exec_top rv_exec_top_i (
      .clk       (clk),
      .reset_i   (reset_i),
      .apb_req_i (apb_req),
      .prdata_o  (prdata),
      .pready_o  (pready),
      .pslverr_o (pslverr)
   );

   always #5 clk = ~clk;

   task automatic check(input string name, input logic [31:0] exp_val, input logic [31:0] act_val);
      checks++;
      if (exp_val !== act_val) begin
         errors++;
         $display("[FAIL] %s: expected %08h, actual %08h", name, exp_val, act_val);
      end
   endtask

   // Runs one APB transfer and samples it at the edge that completes the access cycle.
   task automatic apb_transfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                               input logic [`XLEN_W-1:0] wdata,
                               output logic [`XLEN_W-1:0] rdata, output logic err);
      int waited;
      @(negedge clk);
      apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
      @(negedge clk);
      apb_req.penable = 1'b1;
      waited = 0;
      do begin
         @(posedge clk);
         rdata = prdata;
         err   = pslverr;
         waited++;
      end while (!pready && waited < TIMEOUT);
      if (!pready) begin
         $display("APB transfer to %03h never saw pready", addr);
         $display("TEST FAIL");
         $finish;
      end else begin
         @(negedge clk);
         apb_req = '0;
      end
   endtask

   // Legal RV32I words are LUI, OP-IMM with a valid shift funct7 and OP with a valid funct7.
   function automatic logic legal(input logic [`XLEN_W-1:0] w);
      logic [2:0] f3;
      logic [6:0] f7;
      logic       ok;
      f3 = w[14:12];
      f7 = w[31:25];
      case (w[6:0])
         LUI_OP:  ok = 1'b1;
         I_OP:    ok = (f3 == 3'b001) ? (f7 == BASE) :
                       (f3 == 3'b101) ? (f7 == BASE || f7 == ALT) : 1'b1;
         RR_OP:   ok = (f7 == BASE) || (f7 == ALT && (f3 == 3'b000 || f3 == 3'b101));
         default: ok = 1'b0;
      endcase
      return ok;
   endfunction

   function automatic logic [`XLEN_W-1:0] ref_result(input logic [`XLEN_W-1:0] w);
      logic [`XLEN_W-1:0] a;
      logic [`XLEN_W-1:0] b;
      logic [`XLEN_W-1:0] r;
      logic               alt;
      a   = shadow[w[19:15]];
      b   = (w[6:0] == I_OP) ? {{20{w[31]}}, w[31:20]} : shadow[w[24:20]];
      alt = w[30]; // Bit 5 of funct7 picks SUB and SRA.
      case (w[14:12])
         3'b000:  r = (alt && w[6:0] == RR_OP) ? a - b : a + b;
         3'b001:  r = a << b[4:0];
         3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b011:  r = (a < b) ? 32'd1 : 32'd0;
         3'b100:  r = a ^ b;
         3'b101:  r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'b110:  r = a | b;
         default: r = a & b;
      endcase
      if (w[6:0] == LUI_OP) begin
         r = {w[31:12], 12'h000};
      end
      return r;
   endfunction

   task automatic exec_instr(input logic [`XLEN_W-1:0] word);
      logic [`XLEN_W-1:0] unused;
      logic               err;
      apb_transfer(1'b1, `ADDR_INSTR, word, unused, err);
      check({cur_test, " instr write pslverr"}, 32'd0, 32'(err));
      if (!legal(word)) begin
         exp_illegal = 1'b1;
      end else begin
         if (word[11:7] != 5'd0) begin
            shadow[word[11:7]] = ref_result(word);
         end
         exp_retired = exp_retired + 16'd1;
      end
   endtask

   task automatic verify_regs(input string test);
      logic [`XLEN_W-1:0] data;
      logic               err;
      reg_name_e          rn;
      for (int n = 0; n < `NUM_REGS; n++) begin
         rn = reg_name_e'(n[4:0]);
         apb_transfer(1'b0, 12'(`ADDR_REG_BASE + 4 * n), '0, data, err);
         check($sformatf("%s %s", test, rn.name()), shadow[n], data);
         check($sformatf("%s %s pslverr", test, rn.name()), 32'd0, 32'(err));
      end
   endtask

   task automatic check_status(input string test);
      logic [`XLEN_W-1:0] data;
      logic               err;
      status_t            exp_status;
      exp_status = '{illegal_seen: exp_illegal, reserved: '0, retired_count: exp_retired};
      apb_transfer(1'b0, `ADDR_STATUS, '0, data, err);
      check({test, " status"}, exp_status, data);
   endtask

   task automatic report_test(input string test);
      if (errors == test_errors) begin
         $display("test %s: ok", test);
      end else begin
         $display("test %s: %0d errors", test, errors - test_errors);
      end
      test_errors = errors;
   endtask

   initial begin
      int                 sel;
      logic [`XLEN_W-1:0] data;
      logic               err;
      logic [2:0]         f3;
      logic [6:0]         f7;
      logic [11:0]        imm;
      void'($urandom(32'h1645));
      reset_i     = 1'b1;
      apb_req     = '0;
      checks      = 0;
      errors      = 0;
      test_errors = 0;
      exp_illegal = 1'b0;
      exp_retired = '0;
      cur_test    = "reset_state";
      for (int n = 0; n < `NUM_REGS; n++) begin
         shadow[n] = '0;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;

      verify_regs("reset_state");
      check_status("reset_state");
      report_test("reset_state");

      cur_test = "op_imm";
      exec_instr({12'hff8, 5'd0, ADD_F3, 5'd5, I_OP});         // ADDI x5, x0, -8.
      exec_instr({7'b0100000, 5'd1, 5'd5, SR_F3, 5'd6, I_OP}); // SRAI x6, x5, 1.
      verify_regs("op_imm srai");
      repeat (40) begin
         f3  = 3'($urandom_range(7));
         imm = 12'($urandom);
         if (f3 == 3'b001) begin
            imm[11:5] = BASE;
         end else if (f3 == 3'b101) begin
            imm[11:5] = ($urandom_range(1) == 1) ? ALT : BASE;
         end
         exec_instr({imm, 5'($urandom), f3, 5'($urandom), I_OP});
      end
      verify_regs("op_imm");
      check_status("op_imm");
      report_test("op_imm");

      cur_test = "r_type";
      for (int i = 0; i < 60; i++) begin
         sel = (i < 10) ? i : int'($urandom_range(9)); // First ten cover every operation.
         f3  = (sel < 8) ? 3'(sel) : ((sel == 8) ? 3'b000 : 3'b101);
         f7  = (sel < 8) ? BASE : ALT;
         exec_instr({f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), RR_OP});
      end
      exec_instr({20'h80000, 5'd1, LUI_OP});                  // x1 = 0x80000000.
      exec_instr({12'hfff, 5'd1, ADD_F3, 5'd2, I_OP});        // x2 = 0x7fffffff.
      exec_instr({BASE, 5'd2, 5'd1, SLT_F3, 5'd3, RR_OP});
      exec_instr({BASE, 5'd2, 5'd1, SLTU_F3, 5'd4, RR_OP});
      verify_regs("r_type");
      check_status("r_type");
      report_test("r_type");

      cur_test = "lui_x0";
      repeat (8) exec_instr({20'($urandom), 5'($urandom), LUI_OP});
      exec_instr({20'habcde, 5'd0, LUI_OP});
      exec_instr({12'h123, 5'd1, ADD_F3, 5'd0, I_OP});
      exec_instr({BASE, 5'd2, 5'd1, OR_F3, 5'd0, RR_OP});
      verify_regs("lui_x0");
      check_status("lui_x0");
      report_test("lui_x0");

      cur_test = "illegal";
      exec_instr(32'h0000_2083);                                 // LW x1, 0(x0).
      exec_instr(32'h0010_2023);                                 // SW x1, 0(x0).
      exec_instr(32'h0020_8063);                                 // BEQ x1, x2, 0.
      exec_instr(32'h0000_00ef);                                 // JAL x1, 0.
      exec_instr({7'b0000001, 5'd3, 5'd1, SR_F3, 5'd2, I_OP});
      exec_instr({7'b0000001, 5'd2, 5'd1, ADD_F3, 5'd3, RR_OP});
      verify_regs("illegal");
      check_status("illegal");
      apb_transfer(1'b1, `ADDR_STATUS, '1, data, err);
      exp_illegal = 1'b0;
      exp_retired = '0;
      check_status("status_clear");
      report_test("illegal");

      cur_test = "slave_err";
      apb_transfer(1'b1, 12'(`ADDR_REG_BASE + 8), 32'h1234_5678, data, err);
      check("slave_err reg window write pslverr", 32'd1, 32'(err));
      apb_transfer(1'b0, 12'h010, '0, data, err);
      check("slave_err unmapped read pslverr", 32'd1, 32'(err));
      apb_transfer(1'b1, 12'h7fc, '0, data, err);
      check("slave_err unmapped write pslverr", 32'd1, 32'(err));
      apb_transfer(1'b0, `ADDR_STATUS, '0, data, err);
      check("slave_err status read pslverr", 32'd0, 32'(err));
      verify_regs("slave_err");
      report_test("slave_err");

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
